// ==== src/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

    // address split and array geometry
    localparam int TAG_W    = 23;
    localparam int INDEX_W  = 6;
    localparam int OFFSET_W = 3;
    localparam int ADDR_W   = TAG_W + INDEX_W + OFFSET_W;

    localparam int NUM_SETS = 64;
    localparam int NUM_WAYS = 2;

    localparam int WORD_W   = 32;
    localparam int LINE_W   = 64;

    // offset bit that picks the word inside a line
    localparam int WORD_SEL = 2;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        MISS,
        REPLACE
    } cache_state_e;

    // one fetch request, laid out as the byte address
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } cache_req_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    typedef struct packed {
        logic hit;
        logic way;
    } lookup_result_t;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [LINE_W-1:0] line_t;
    typedef logic [ADDR_W-1:0] mem_addr_t;

endpackage

`default_nettype wire

// ==== src/icache_ctrl.sv ====
`default_nettype none

module icache_ctrl
    import icache_pkg::*;
(
    input  wire logic           clk,
    input  wire logic           rst,
    // fetch pipeline
    input  wire logic           valid,
    input  wire cache_req_t     req,
    // from the tag array
    input  wire lookup_result_t result,
    output logic                addr_ok,
    output logic                data_ok,
    // memory read port
    output logic                rd_req,
    output mem_addr_t           rd_addr,
    // array controls
    output logic                lookup_en,
    output logic [INDEX_W-1:0]  lookup_index,
    output logic                capture_en,
    output logic                refill_en,
    output cache_req_t          req_q
);

    cache_state_e state;
    cache_state_e next_state;
    logic         accept;
    logic         lookup_hit;

    assign lookup_hit = (state == LOOKUP) && result.hit;

    // new request can ride in behind a hit
    assign addr_ok = (state == IDLE) || lookup_hit;
    assign accept  = valid && addr_ok;

    assign lookup_en    = accept;
    assign lookup_index = req.index;

    // miss completes from the refill register in REPLACE
    assign data_ok    = lookup_hit || (state == REPLACE);
    assign rd_req     = (state == MISS);
    assign capture_en = (state == MISS);
    assign refill_en  = (state == REPLACE);

    // line address, offset forced to zero
    assign rd_addr = {req_q.tag, req_q.index, {OFFSET_W{1'b0}}};

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    next_state = LOOKUP;
                end
            end
            LOOKUP: begin
                if (!result.hit) begin
                    next_state = MISS;
                end else if (!valid) begin
                    next_state = IDLE;
                end
            end
            MISS: begin
                next_state = REPLACE;
            end
            REPLACE: begin
                next_state = IDLE;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // request buffer
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
    end

endmodule

`default_nettype wire

// ==== src/icache_tag_array.sv ====
`default_nettype none

module icache_tag_array
    import icache_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               lookup_en,
    input  wire logic [INDEX_W-1:0] lookup_index,
    input  wire logic               refill_en,
    input  wire cache_req_t         req_q,
    output lookup_result_t          result,
    output logic                    victim_way
);

    // valid bits per way, tags kept apart
    logic [NUM_SETS-1:0] valid_q [NUM_WAYS];
    logic [TAG_W-1:0]    tag_mem [NUM_WAYS][NUM_SETS];

    // round-robin pointer per set
    logic [NUM_SETS-1:0] victim_q;

    tag_entry_t          rd_entry [NUM_WAYS];
    logic [NUM_WAYS-1:0] way_hit;

    assign victim_way = victim_q[req_q.index];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                valid_q[w] <= '0;
            end
            victim_q <= '0;
        end else if (refill_en) begin
            valid_q[victim_way][req_q.index] <= 1'b1;
            victim_q[req_q.index]            <= ~victim_way;
        end
    end

    always_ff @(posedge clk) begin
        if (refill_en) begin
            tag_mem[victim_way][req_q.index] <= req_q.tag;
        end
    end

    // synchronous read of both ways
    always_ff @(posedge clk) begin
        if (lookup_en) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                rd_entry[w].valid <= valid_q[w][lookup_index];
                rd_entry[w].tag   <= tag_mem[w][lookup_index];
            end
        end
    end

    // compare against the buffered request
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = rd_entry[w].valid && (rd_entry[w].tag == req_q.tag);
        end
    end

    assign result.hit = |way_hit;
    assign result.way = way_hit[1];

endmodule

`default_nettype wire

// ==== src/icache_data_array.sv ====
`default_nettype none

module icache_data_array
    import icache_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               lookup_en,
    input  wire logic [INDEX_W-1:0] lookup_index,
    input  wire logic               capture_en,
    input  wire line_t              ret_data,
    input  wire logic               refill_en,
    input  wire logic               victim_way,
    input  wire cache_req_t         req_q,
    input  wire lookup_result_t     result,
    output word_t                   rdata
);

    line_t line_mem [NUM_WAYS][NUM_SETS];
    line_t rd_line  [NUM_WAYS];
    line_t refill_line;
    line_t hit_line;
    line_t src_line;

    // line written back at the end of REPLACE
    always_ff @(posedge clk) begin
        if (refill_en) begin
            line_mem[victim_way][req_q.index] <= refill_line;
        end
    end

    // both ways read together, as in a single wide RAM
    always_ff @(posedge clk) begin
        if (lookup_en) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                rd_line[w] <= line_mem[w][lookup_index];
            end
        end
    end

    // memory line held from MISS into REPLACE
    always_ff @(posedge clk) begin
        if (capture_en) begin
            refill_line <= ret_data;
        end
    end

    assign hit_line = result.hit ? rd_line[result.way] : '0;

    // refill register bypasses the arrays on a miss
    assign src_line = refill_en ? refill_line : hit_line;

    assign rdata = req_q.offset[WORD_SEL] ? src_line[LINE_W-1 -: WORD_W]
                                          : src_line[WORD_W-1:0];

endmodule

`default_nettype wire

// ==== src/icache.sv ====
`default_nettype none

module icache
    import icache_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    // fetch pipeline
    input  wire logic       valid,
    input  wire cache_req_t req,
    output logic            addr_ok,
    output logic            data_ok,
    output word_t           rdata,
    // memory read port
    output logic            rd_req,
    output mem_addr_t       rd_addr,
    input  wire line_t      ret_data
);

    lookup_result_t     result;
    logic               lookup_en;
    logic [INDEX_W-1:0] lookup_index;
    logic               capture_en;
    logic               refill_en;
    logic               victim_way;
    cache_req_t         req_q;

    icache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .valid        (valid),
        .req          (req),
        .result       (result),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .rd_req       (rd_req),
        .rd_addr      (rd_addr),
        .lookup_en    (lookup_en),
        .lookup_index (lookup_index),
        .capture_en   (capture_en),
        .refill_en    (refill_en),
        .req_q        (req_q)
    );

    icache_tag_array u_tag_array (
        .clk          (clk),
        .rst          (rst),
        .lookup_en    (lookup_en),
        .lookup_index (lookup_index),
        .refill_en    (refill_en),
        .req_q        (req_q),
        .result       (result),
        .victim_way   (victim_way)
    );

    icache_data_array u_data_array (
        .clk          (clk),
        .lookup_en    (lookup_en),
        .lookup_index (lookup_index),
        .capture_en   (capture_en),
        .ret_data     (ret_data),
        .refill_en    (refill_en),
        .victim_way   (victim_way),
        .req_q        (req_q),
        .result       (result),
        .rdata        (rdata)
    );

endmodule

`default_nettype wire

// ==== verification/icache_tb.sv ====
`default_nettype none

module icache_tb
    import icache_pkg::*;
();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_REQS     = 64;
    localparam int REC_W        = 5;
    localparam logic [31:0] MEM_KEY  = 32'h9e3779b9;
    localparam logic [31:0] END_MARK = 32'hffffffff;

    // one accepted request waiting for its response
    typedef struct packed {
        cache_req_t req;
        logic       miss;
        int         accept_cycle;
        int         num;
    } pending_t;

    logic       clk;
    logic       rst;
    logic       valid;
    cache_req_t req;
    logic       addr_ok;
    logic       data_ok;
    word_t      rdata;
    logic       rd_req;
    mem_addr_t  rd_addr;
    line_t      ret_data;

    // five hex words per request in the order tag index offset miss gap
    logic [31:0] stim_mem [REC_W*MAX_REQS];
    pending_t    pending [$];
    int          n_req;
    int          n_done;
    int          cycle;

    icache dut (
        .clk      (clk),
        .rst      (rst),
        .valid    (valid),
        .req      (req),
        .addr_ok  (addr_ok),
        .data_ok  (data_ok),
        .rdata    (rdata),
        .rd_req   (rd_req),
        .rd_addr  (rd_addr),
        .ret_data (ret_data)
    );

    function automatic word_t mem_word(input mem_addr_t a);
        return a ^ MEM_KEY;
    endfunction

    // byte address of the request with the offset cleared
    function automatic mem_addr_t line_addr(input cache_req_t r);
        return mem_addr_t'(r) & 32'hffff_fff8;
    endfunction

    function automatic word_t expected_word(input cache_req_t r);
        return mem_word(line_addr(r) + (r.offset[2] ? 32'd4 : 32'd0));
    endfunction

    // zero-latency memory
    assign ret_data = {mem_word(rd_addr + 32'd4), mem_word(rd_addr)};

    function automatic cache_req_t record_req(input int i);
        cache_req_t r;
        r.tag    = stim_mem[REC_W*i][TAG_W-1:0];
        r.index  = stim_mem[REC_W*i+1][INDEX_W-1:0];
        r.offset = stim_mem[REC_W*i+2][OFFSET_W-1:0];
        return r;
    endfunction

    function automatic int pick_idle(input int i);
        return int'($urandom_range(stim_mem[REC_W*i+4], 0));
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at time %0t: %s is %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_addr(input mem_addr_t got, input mem_addr_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at time %0t: %s is %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_hit(input logic got_miss, input logic exp_miss, input int num);
        if (got_miss !== exp_miss) begin
            abort_run($sformatf("mismatch at time %0t: request %0d miss is %b, expected %b",
                                $time, num, got_miss, exp_miss));
        end
    endtask

    task automatic check_strobe(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at time %0t: %s is %b, expected %b",
                                $time, what, got, exp));
        end
    endtask

    // outputs sampled at the falling edge with age counted from acceptance
    task automatic check_cycle();
        pending_t p;
        int       age;
        if (pending.size() == 0) begin
            check_strobe(addr_ok, 1'b1, "addr_ok with nothing pending");
            check_strobe(data_ok, 1'b0, "data_ok with nothing pending");
            check_strobe(rd_req, 1'b0, "rd_req with nothing pending");
            return;
        end
        p   = pending[0];
        age = cycle - p.accept_cycle;
        if (age == 1) begin
            check_hit(!data_ok, p.miss, p.num);
        end
        check_strobe(data_ok, p.miss ? (age == 3) : (age == 1), "data_ok");
        check_strobe(rd_req, p.miss && (age == 2), "rd_req");
        // a hit takes the next request, a refill stalls it
        check_strobe(addr_ok, !p.miss, "addr_ok");
        if (rd_req) begin
            check_addr(rd_addr, line_addr(p.req), "rd_addr");
        end
        if (data_ok) begin
            check_word(rdata, expected_word(p.req), "rdata");
            void'(pending.pop_front());
            n_done++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // watchdog allows 20 cycles per request on top of reset
    initial begin
        int limit;
        wait (n_req > 0);
        limit = (n_req * 20 + RESET_CYCLES) * CLK_PERIOD;
        #(limit);
        abort_run("timeout: the request list did not finish in time");
    end

    initial begin
        int       req_idx;
        int       idle_left;
        pending_t p;
        void'($urandom(32'h471912cc));
        rst     = 1'b1;
        valid   = 1'b0;
        req     = '0;
        req_idx = 0;
        n_done  = 0;
        cycle   = 0;
        $readmemh("verification/icache_testdata.txt", stim_mem);
        while (n_req < MAX_REQS && stim_mem[REC_W*n_req] !== END_MARK) begin
            n_req++;
        end
        if (n_req == 0 || n_req == MAX_REQS) begin
            abort_run("the data file has no requests or no end marker");
        end
        idle_left = pick_idle(0);
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_strobe(addr_ok, 1'b1, "addr_ok after reset");
        check_strobe(data_ok, 1'b0, "data_ok after reset");
        check_strobe(rd_req, 1'b0, "rd_req after reset");
        while (n_done < n_req) begin
            @(posedge clk);
            if (req_idx < n_req && idle_left == 0) begin
                valid <= 1'b1;
                req   <= record_req(req_idx);
            end else begin
                valid <= 1'b0;
                if (idle_left > 0) begin
                    idle_left--;
                end
            end
            @(negedge clk);
            cycle++;
            check_cycle();
            if (valid && addr_ok) begin
                p.req          = req;
                p.miss         = stim_mem[REC_W*req_idx+3][0];
                p.accept_cycle = cycle;
                p.num          = req_idx;
                pending.push_back(p);
                req_idx++;
                if (req_idx < n_req) begin
                    idle_left = pick_idle(req_idx);
                end
            end
        end
        repeat (2) begin
            @(negedge clk);
            check_strobe(addr_ok, 1'b1, "addr_ok after the last response");
            check_strobe(data_ok, 1'b0, "data_ok after the last response");
            check_strobe(rd_req, 1'b0, "rd_req after the last response");
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== icache.f ====
src/icache_pkg.sv
src/icache_ctrl.sv
src/icache_tag_array.sv
src/icache_data_array.sv
src/icache.sv
verification/icache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the icache testbench with Verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module icache_tb -f icache.f -o icache_sim \
    || { echo "verilator build failed"; exit 1; }

./obj_dir/icache_sim > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log

grep -q "CHECKS FAILED" sim.log && { echo "FAIL"; exit 1; }
grep -q "simulator exited with an error" sim.log && { echo "FAIL"; exit 1; }
echo "PASS"

// ==== verification/icache_testdata.txt ====
// columns in hex: tag index offset expected_miss gap
// gap is the most idle cycles put in before the request, ffffffff ends the list
000100 00 0 1 0
000100 00 4 0 2
000100 00 0 0 0
000200 01 4 1 3
000200 01 0 0 0
000300 02 0 1 0
// two tags in set 05, then a third one evicts the first
0000a1 05 0 1 1
0000a2 05 4 1 0
0000a1 05 4 0 0
0000a2 05 0 0 2
0000a3 05 0 1 0
0000a2 05 4 0 0
0000a1 05 0 1 3
0000a3 05 4 0 0
0000a1 05 6 0 0
// back to back run with a miss inside
000100 00 4 0 4
000200 01 1 0 0
000100 00 0 0 0
000200 01 5 0 0
0000a3 05 0 0 0
000400 03 0 1 0
000400 03 4 0 0
000100 00 3 0 0
000300 02 4 0 0
7fffff 3f 4 1 2
7fffff 3f 0 0 0
000100 3f 0 1 0
7fffff 3f 4 0 0
000100 3f 4 0 0
ffffffff
